// File: ipic_consts.svh
// ----------------------------------------------------------
// Sizes, register map and ICSR layout for a 16-line IPIC
// Line count is fixed; the vector width assumes 16 lines + void
// ----------------------------------------------------------
`ifndef IPIC_CONSTS_SVH
`define IPIC_CONSTS_SVH

// ----------------------------------------------------------
// Sizes
// ----------------------------------------------------------
`define IPIC_LINES_NUM  16        // External lines
`define IPIC_LINE_W     4         // Line number width
`define IPIC_VECT_W     5         // Vector number, MSB marks void
`define IPIC_VOID_VECT  5'd16     // CISV with nothing in service
`define IPIC_XLEN       32        // Read/write data width
`define IPIC_ADDR_W     3         // Register address width

// ----------------------------------------------------------
// Register addresses
// ----------------------------------------------------------
// Address 1 is the unused slot
`define IPIC_ADDR_CISV  3'd0      // Vector in service, RO
`define IPIC_ADDR_IPR   3'd2      // Pending, W1C
`define IPIC_ADDR_ISVR  3'd3      // In-service bits, RO
`define IPIC_ADDR_EOI   3'd4      // End of interrupt
`define IPIC_ADDR_SOI   3'd5      // Start of interrupt
`define IPIC_ADDR_IDX   3'd6      // Line index for ICSR
`define IPIC_ADDR_ICSR  3'd7      // Per-line control/status

// ----------------------------------------------------------
// ICSR bit positions
// ----------------------------------------------------------
`define ICSR_IP         0         // Pending
`define ICSR_IE         1         // Enable
`define ICSR_IM         2         // Mode: 0 level, 1 edge
`define ICSR_INV        3         // Line inversion
`define ICSR_IS         4         // In service
`define ICSR_LN_LSB     12        // Line number field, 15:12

`endif

// File: ipic_pkg.sv
// ----------------------------------------------------------
// Vector types for the IPIC, sized from the constants header
// ----------------------------------------------------------
`default_nettype none

`include "ipic_consts.svh"

package ipic_pkg;

    // One bit per line: lines, pending, in-service, strobes
    typedef logic [`IPIC_LINES_NUM-1:0] irq_vec_t;

    // Line number 0..15
    typedef logic [`IPIC_LINE_W-1:0]    line_idx_t;

    // Vector number, top bit set means void
    typedef logic [`IPIC_VECT_W-1:0]    vect_idx_t;

    // Register address
    typedef logic [`IPIC_ADDR_W-1:0]    reg_addr_t;

    // CPU side data
    typedef logic [`IPIC_XLEN-1:0]      xlen_data_t;

endpackage

`default_nettype wire

// File: ipic_reg_decode.sv
// ----------------------------------------------------------
// Write decode only; reads are muxed in the service controller
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ipic_consts.svh"

module ipic_reg_decode (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   w_req_i,    // Write strobe, one cycle
    input  wire ipic_pkg::reg_addr_t    addr_i,
    input  wire ipic_pkg::xlen_data_t   wdata_i,
    output ipic_pkg::line_idx_t         idx_o,      // IDX register
    output ipic_pkg::irq_vec_t          icsr_wr_o,  // One-hot ICSR write
    output ipic_pkg::irq_vec_t          ipr_clr_o,  // IPR write-one-to-clear
    output logic                        eoi_wr_o,
    output logic                        soi_wr_o
);

    import ipic_pkg::*;

    logic       idx_wr;         // IDX write this cycle
    logic       icsr_wr;        // ICSR write this cycle
    logic       ipr_wr;         // IPR write this cycle
    line_idx_t  idx_q;
    irq_vec_t   idx_onehot;     // Decoded index

    // ------------------------------------------------------
    // Address decode
    // ------------------------------------------------------
    always_comb begin
        idx_wr   = 1'b0;
        icsr_wr  = 1'b0;
        ipr_wr   = 1'b0;
        eoi_wr_o = 1'b0;
        soi_wr_o = 1'b0;
        if (w_req_i) begin
            case (addr_i)
                `IPIC_ADDR_IPR:  ipr_wr   = 1'b1;
                `IPIC_ADDR_EOI:  eoi_wr_o = 1'b1;
                `IPIC_ADDR_SOI:  soi_wr_o = 1'b1;
                `IPIC_ADDR_IDX:  idx_wr   = 1'b1;
                `IPIC_ADDR_ICSR: icsr_wr  = 1'b1;
                // CISV, ISVR read-only; slot 1 unused
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------------
    // Index register
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (idx_wr) begin
            idx_q <= wdata_i[`IPIC_LINE_W-1:0];   // Upper bits dropped
        end
    end

    assign idx_o = idx_q;

    // Slices see only their own strobe, no index compare there
    assign idx_onehot = irq_vec_t'(1) << idx_q;
    assign icsr_wr_o  = icsr_wr ? idx_onehot : '0;

    // Ones in the low 16 bits request a pending clear
    assign ipr_clr_o = ipr_wr ? wdata_i[`IPIC_LINES_NUM-1:0] : '0;

endmodule

`default_nettype wire

// File: ipic_irq_line.sv
// ----------------------------------------------------------
// One line slice; input is async and always double-synced
// Level-mode pending cannot be cleared while the source is active
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ipic_irq_line (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   irq_line_i,     // Raw external line
    input  wire logic   icsr_wr_i,      // ICSR write to this line
    input  wire logic   ie_i,           // Write data bits
    input  wire logic   im_i,
    input  wire logic   inv_i,
    input  wire logic   ipr_clr_i,      // Clear request from IPR write
    input  wire logic   serv_start_i,   // This line started
    input  wire logic   serv_end_i,     // This line ended
    output logic        pend_o,
    output logic        ena_o,
    output logic        mode_o,
    output logic        inv_o,
    output logic        insvc_o
);

    logic   sync_meta;      // First sync stage
    logic   line_q;         // Synchronized line
    logic   line_dly;       // Line one cycle later
    logic   ie_q;
    logic   im_q;
    logic   inv_q;
    logic   is_q;
    logic   pend_q;
    logic   pend_next;
    logic   im_next;        // Mode incl. a write this cycle
    logic   inv_next;       // Inversion incl. a write this cycle
    logic   lvl;            // Active level after inversion
    logic   edge_det;       // Change towards the active level
    logic   clr_req;
    logic   clr_ok;

    // ------------------------------------------------------
    // Synchronizer and edge history
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta <= 1'b0;
            line_q    <= 1'b0;
            line_dly  <= 1'b0;
        end else begin
            sync_meta <= irq_line_i;
            line_q    <= sync_meta;
            line_dly  <= line_q;
        end
    end

    assign im_next  = icsr_wr_i ? im_i  : im_q;
    assign inv_next = icsr_wr_i ? inv_i : inv_q;

    assign lvl      = line_q ^ inv_next;
    assign edge_det = (line_q ^ line_dly) & lvl;

    // ------------------------------------------------------
    // Pending
    // ------------------------------------------------------
    // Edge mode always clears; level mode only once source dropped
    assign clr_req = ipr_clr_i | serv_start_i;
    assign clr_ok  = clr_req & (~lvl | im_next);

    always_comb begin
        if (clr_ok) begin
            pend_next = 1'b0;
        end else if (!im_q) begin
            pend_next = lvl;                // Level follows source
        end else begin
            pend_next = pend_q | edge_det;  // Edge is sticky
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= pend_next;
        end
    end

    // ------------------------------------------------------
    // Control bits and in-service
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ie_q  <= 1'b0;
            im_q  <= 1'b0;
            inv_q <= 1'b0;
        end else if (icsr_wr_i) begin
            ie_q  <= ie_i;
            im_q  <= im_i;
            inv_q <= inv_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_q <= 1'b0;
        end else if (serv_start_i) begin
            is_q <= 1'b1;
        end else if (serv_end_i) begin
            is_q <= 1'b0;
        end
    end

    assign pend_o  = pend_q;
    assign ena_o   = ie_q;
    assign mode_o  = im_q;
    assign inv_o   = inv_q;
    assign insvc_o = is_q;

endmodule

`default_nettype wire

// File: ipic_serv_ctrl.sv
// ----------------------------------------------------------
// Fixed priority, line 0 highest; CISV holds 16 when idle
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ipic_consts.svh"

module ipic_serv_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire ipic_pkg::irq_vec_t     pend_i,
    input  wire ipic_pkg::irq_vec_t     ena_i,
    input  wire ipic_pkg::irq_vec_t     mode_i,
    input  wire ipic_pkg::irq_vec_t     inv_i,
    input  wire ipic_pkg::irq_vec_t     insvc_i,
    input  wire ipic_pkg::line_idx_t    idx_i,      // ICSR read index
    input  wire logic                   soi_wr_i,
    input  wire logic                   eoi_wr_i,
    input  wire logic                   r_req_i,
    input  wire ipic_pkg::reg_addr_t    addr_i,
    output ipic_pkg::irq_vec_t          serv_start_o,   // One-hot start
    output ipic_pkg::irq_vec_t          serv_end_o,     // One-hot end
    output logic                        irq_req_o,
    output ipic_pkg::xlen_data_t        rdata_o
);

    import ipic_pkg::*;

    // Lowest set bit, void when none
    function automatic vect_idx_t find_first(input irq_vec_t v);
        vect_idx_t res;
        res = `IPIC_VOID_VECT;
        for (int i = `IPIC_LINES_NUM - 1; i >= 0; i--) begin
            if (v[i]) begin
                res = vect_idx_t'(i);
            end
        end
        return res;
    endfunction

    irq_vec_t   req_v;          // Pending and enabled
    vect_idx_t  req_idx;        // Best candidate
    logic       req_vd;
    vect_idx_t  cisv_q;
    logic       serv_vd;        // Something in service
    line_idx_t  serv_idx;
    logic       start_vd;
    logic       eoi_vd;
    irq_vec_t   isvr_eoi;       // In-service minus the ending line

    // ------------------------------------------------------
    // Priority search and request
    // ------------------------------------------------------
    assign req_v   = pend_i & ena_i;
    assign req_idx = find_first(req_v);
    assign req_vd  = |req_v;

    assign serv_vd  = ~cisv_q[`IPIC_VECT_W-1];
    assign serv_idx = cisv_q[`IPIC_LINE_W-1:0];

    // Void is 16, so any valid candidate beats an idle CISV
    assign irq_req_o = req_vd & (req_idx < cisv_q);

    assign start_vd = soi_wr_i & irq_req_o;
    assign eoi_vd   = eoi_wr_i & serv_vd;   // EOI when idle is ignored

    assign serv_start_o = irq_vec_t'(start_vd) << req_idx[`IPIC_LINE_W-1:0];
    assign serv_end_o   = irq_vec_t'(eoi_vd) << serv_idx;

    assign isvr_eoi = insvc_i & ~serv_end_o;

    // ------------------------------------------------------
    // Vector in service
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cisv_q <= `IPIC_VOID_VECT;
        end else if (start_vd) begin
            cisv_q <= req_idx;              // Nest on top
        end else if (eoi_vd) begin
            cisv_q <= find_first(isvr_eoi); // Back to next in-service
        end
    end

    // ------------------------------------------------------
    // Read mux
    // ------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (r_req_i) begin
            case (addr_i)
                `IPIC_ADDR_CISV: rdata_o = xlen_data_t'(cisv_q);
                `IPIC_ADDR_IPR:  rdata_o = xlen_data_t'(pend_i);
                `IPIC_ADDR_ISVR: rdata_o = xlen_data_t'(insvc_i);
                `IPIC_ADDR_IDX:  rdata_o = xlen_data_t'(idx_i);
                `IPIC_ADDR_ICSR: begin
                    rdata_o[`ICSR_IP]  = pend_i[idx_i];
                    rdata_o[`ICSR_IE]  = ena_i[idx_i];
                    rdata_o[`ICSR_IM]  = mode_i[idx_i];
                    rdata_o[`ICSR_INV] = inv_i[idx_i];
                    rdata_o[`ICSR_IS]  = insvc_i[idx_i];
                    rdata_o[`ICSR_LN_LSB +: `IPIC_LINE_W] = idx_i;
                end
                // EOI, SOI and slot 1 read zero
                default: rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: ipic_top.sv
// ----------------------------------------------------------
// IPIC top; one-cycle register port, no back-pressure
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ipic_consts.svh"

module ipic_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire ipic_pkg::irq_vec_t     irq_lines_i,    // Async sources
    input  wire logic                   r_req_i,
    input  wire logic                   w_req_i,
    input  wire ipic_pkg::reg_addr_t    addr_i,
    input  wire ipic_pkg::xlen_data_t   wdata_i,
    output ipic_pkg::xlen_data_t        rdata_o,
    output logic                        irq_req_o
);

    import ipic_pkg::*;

    line_idx_t  idx;
    irq_vec_t   icsr_wr;
    irq_vec_t   ipr_clr;
    logic       eoi_wr;
    logic       soi_wr;
    irq_vec_t   serv_start;
    irq_vec_t   serv_end;
    irq_vec_t   pend, ena, mode, inv, insvc;    // Slice status

    ipic_reg_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_req_i   (w_req_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .idx_o     (idx),
        .icsr_wr_o (icsr_wr),
        .ipr_clr_o (ipr_clr),
        .eoi_wr_o  (eoi_wr),
        .soi_wr_o  (soi_wr)
    );

    // ------------------------------------------------------
    // Line slices, ICSR fields shared from write data
    // ------------------------------------------------------
    for (genvar i = 0; i < `IPIC_LINES_NUM; i++) begin : g_line
        ipic_irq_line u_line (
            .clk          (clk),
            .rst_n        (rst_n),
            .irq_line_i   (irq_lines_i[i]),
            .icsr_wr_i    (icsr_wr[i]),
            .ie_i         (wdata_i[`ICSR_IE]),
            .im_i         (wdata_i[`ICSR_IM]),
            .inv_i        (wdata_i[`ICSR_INV]),
            .ipr_clr_i    (ipr_clr[i]),
            .serv_start_i (serv_start[i]),
            .serv_end_i   (serv_end[i]),
            .pend_o       (pend[i]),
            .ena_o        (ena[i]),
            .mode_o       (mode[i]),
            .inv_o        (inv[i]),
            .insvc_o      (insvc[i])
        );
    end

    ipic_serv_ctrl u_serv (
        .clk          (clk),
        .rst_n        (rst_n),
        .pend_i       (pend),
        .ena_i        (ena),
        .mode_i       (mode),
        .inv_i        (inv),
        .insvc_i      (insvc),
        .idx_i        (idx),
        .soi_wr_i     (soi_wr),
        .eoi_wr_i     (eoi_wr),
        .r_req_i      (r_req_i),
        .addr_i       (addr_i),
        .serv_start_o (serv_start),
        .serv_end_o   (serv_end),
        .irq_req_o    (irq_req_o),
        .rdata_o      (rdata_o)
    );

endmodule

`default_nettype wire

// File: tb_ipic.sv
// ----------------------------------------------------------
// Self-checking IPIC testbench whose model checks settled states only
// Line changes are held 5 cycles before anything is compared
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ipic_consts.svh"

module tb_ipic;

    import ipic_pkg::*;

    localparam int        CLK_PERIOD  = 40;
    localparam reg_addr_t ADDR_UNUSED = 3'd1;

    // Rounds per test
    localparam int N_ICSR  = 24;
    localparam int N_LEVEL = 24;
    localparam int N_EDGE  = 24;
    localparam int N_NEST  = 64;

    // Each bus access or line drive is one op and a register sweep six
    localparam int OPS_TOTAL = 6 + (8 * N_ICSR + 32) + (32 + 14 * N_LEVEL)
                             + (40 + 22 * N_EDGE) + (159 + 8 * N_NEST) + 16;
    localparam int WATCHDOG_NS = (OPS_TOTAL * 10 + 10) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    irq_vec_t    irq_lines;
    logic        r_req;
    logic        w_req;
    reg_addr_t   addr;
    xlen_data_t  wdata;
    xlen_data_t  rdata;
    logic        irq_req;

    logic [31:0] lfsr_state;

    // ------------------------------------------------------------
    // Reference model state per line
    // ------------------------------------------------------------
    irq_vec_t    m_lines;   // Driven line pattern
    irq_vec_t    m_ie;
    irq_vec_t    m_im;      // 1 = edge mode
    irq_vec_t    m_inv;
    irq_vec_t    m_pend;
    irq_vec_t    m_is;
    vect_idx_t   m_cisv;
    line_idx_t   m_idx;

    ipic_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines),
        .r_req_i     (r_req),
        .w_req_i     (w_req),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .rdata_o     (rdata),
        .irq_req_o   (irq_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in time");
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired");
    end

    // Fibonacci taps 32 22 2 1 with one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // Lowest set bit wins and none gives void
    function automatic vect_idx_t lowest_set(input irq_vec_t v);
        vect_idx_t r;
        r = `IPIC_VOID_VECT;
        for (int i = 0; i < `IPIC_LINES_NUM; i++) begin
            if (v[i] && r == `IPIC_VOID_VECT) begin
                r = vect_idx_t'(i);
            end
        end
        return r;
    endfunction

    function automatic logic expected_irq();
        vect_idx_t best;
        best = lowest_set(m_pend & m_ie);
        if (best == `IPIC_VOID_VECT) begin
            return 1'b0;
        end
        return (m_cisv == `IPIC_VOID_VECT) || (best < m_cisv);   // Idle or preempts
    endfunction

    function automatic xlen_data_t icsr_expect(input line_idx_t l);
        xlen_data_t r;
        r = '0;
        r[`ICSR_IP]  = m_pend[l];
        r[`ICSR_IE]  = m_ie[l];
        r[`ICSR_IM]  = m_im[l];
        r[`ICSR_INV] = m_inv[l];
        r[`ICSR_IS]  = m_is[l];
        r[`ICSR_LN_LSB +: `IPIC_LINE_W] = l;
        return r;
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_rdata(input string name, input xlen_data_t exp, input xlen_data_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Read data mismatch");
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected irq %b, actual irq %b", name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Request output mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Bus access driven on the falling edge
    // ------------------------------------------------------------
    task automatic bus_write(input reg_addr_t a, input xlen_data_t d);
        @(negedge clk);
        addr  = a;
        wdata = d;
        w_req = 1'b1;       // Acts on the next rising edge
        @(negedge clk);
        w_req = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t a, output xlen_data_t d);
        @(negedge clk);
        addr  = a;
        r_req = 1'b1;
        #(CLK_PERIOD / 4);
        d = rdata;          // Combinational and settled mid low phase
        @(negedge clk);
        r_req = 1'b0;
        #(CLK_PERIOD / 4);
        check_rdata("idle_read", '0, rdata);
    endtask

    // Read started on the falling edge where a write ends
    task automatic read_next_cycle(input reg_addr_t a, output xlen_data_t d);
        addr  = a;
        r_req = 1'b1;
        #(CLK_PERIOD / 4);
        d = rdata;
        @(negedge clk);
        r_req = 1'b0;
    endtask

    task automatic sample_irq(input string name);
        @(negedge clk);
        #(CLK_PERIOD / 4);
        check_irq(name, expected_irq(), irq_req);
    endtask

    // ------------------------------------------------------------
    // Stimulus with model update
    // ------------------------------------------------------------
    task automatic set_lines(input irq_vec_t v);
        logic lvl;
        @(negedge clk);
        irq_lines = v;
        for (int i = 0; i < `IPIC_LINES_NUM; i++) begin
            lvl = v[i] ^ m_inv[i];
            if (!m_im[i]) begin
                m_pend[i] = lvl;                    // Level follows source
            end else if (lvl && (v[i] != m_lines[i])) begin
                m_pend[i] = 1'b1;                   // Edge into active level
            end
        end
        m_lines = v;
        repeat (5) @(negedge clk);                  // Sync plus pending flop
    endtask

    task automatic pulse_line(input line_idx_t l);
        irq_vec_t bit_l;
        bit_l = irq_vec_t'(1) << l;
        set_lines(m_lines | bit_l);
        set_lines(m_lines & ~bit_l);
    endtask

    task automatic write_idx(input xlen_data_t w);
        bus_write(`IPIC_ADDR_IDX, w);
        m_idx = w[`IPIC_LINE_W-1:0];        // Upper bits dropped
    endtask

    task automatic write_icsr(input xlen_data_t w);
        bus_write(`IPIC_ADDR_ICSR, w);
        // Level mode on either side reloads pending from new level
        if (!m_im[m_idx] || !w[`ICSR_IM]) begin
            m_pend[m_idx] = m_lines[m_idx] ^ w[`ICSR_INV];
        end
        m_ie[m_idx]  = w[`ICSR_IE];
        m_im[m_idx]  = w[`ICSR_IM];
        m_inv[m_idx] = w[`ICSR_INV];
    endtask

    task automatic config_line(input line_idx_t l, input logic ie, input logic im,
                               input logic inv);
        xlen_data_t w;
        w = '0;
        w[`ICSR_IE]  = ie;
        w[`ICSR_IM]  = im;
        w[`ICSR_INV] = inv;
        write_idx(xlen_data_t'(l));
        write_icsr(w);
    endtask

    task automatic write_ipr(input irq_vec_t mask);
        xlen_data_t d;
        bus_write(`IPIC_ADDR_IPR, xlen_data_t'(mask));
        for (int i = 0; i < `IPIC_LINES_NUM; i++) begin
            if (mask[i] && (m_im[i] || !(m_lines[i] ^ m_inv[i]))) begin
                m_pend[i] = 1'b0;   // Level stays while active
            end
        end
        read_next_cycle(`IPIC_ADDR_IPR, d);     // Before level mode could reload
        check_rdata("ipr_next_cycle", xlen_data_t'(m_pend), d);
    endtask

    task automatic write_soi();
        vect_idx_t b;
        logic      go;
        go = expected_irq();
        b  = lowest_set(m_pend & m_ie);
        bus_write(`IPIC_ADDR_SOI, '0);
        if (go) begin
            m_is[b[`IPIC_LINE_W-1:0]] = 1'b1;
            m_cisv = b;
            if (m_im[b[`IPIC_LINE_W-1:0]]
                || !(m_lines[b[`IPIC_LINE_W-1:0]] ^ m_inv[b[`IPIC_LINE_W-1:0]])) begin
                m_pend[b[`IPIC_LINE_W-1:0]] = 1'b0;
            end
        end
    endtask

    task automatic write_eoi();
        bus_write(`IPIC_ADDR_EOI, '0);
        if (m_cisv != `IPIC_VOID_VECT) begin    // Ignored when idle
            m_is[m_cisv[`IPIC_LINE_W-1:0]] = 1'b0;
            m_cisv = lowest_set(m_is);
        end
    endtask

    // Full register sweep plus request output
    task automatic verify_regs(input string name);
        xlen_data_t d;
        bus_read(`IPIC_ADDR_CISV, d);
        check_rdata({name, " CISV"}, xlen_data_t'(m_cisv), d);
        bus_read(`IPIC_ADDR_IPR, d);
        check_rdata({name, " IPR"}, xlen_data_t'(m_pend), d);
        bus_read(`IPIC_ADDR_ISVR, d);
        check_rdata({name, " ISVR"}, xlen_data_t'(m_is), d);
        bus_read(`IPIC_ADDR_IDX, d);
        check_rdata({name, " IDX"}, xlen_data_t'(m_idx), d);
        bus_read(`IPIC_ADDR_ICSR, d);
        check_rdata({name, " ICSR"}, icsr_expect(m_idx), d);
        sample_irq(name);
    endtask

    task automatic verify_icsr(input string name, input line_idx_t l);
        xlen_data_t d;
        write_idx(xlen_data_t'(l));
        bus_read(`IPIC_ADDR_ICSR, d);
        check_rdata(name, icsr_expect(l), d);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        xlen_data_t  d;
        logic [31:0] w;
        irq_vec_t    idle;

        lfsr_state = 32'h5407;
        rst_n      = 1'b0;
        irq_lines  = '0;
        r_req      = 1'b0;
        w_req      = 1'b0;
        addr       = '0;
        wdata      = '0;
        m_lines    = '0;
        m_ie       = '0;
        m_im       = '0;
        m_inv      = '0;
        m_pend     = '0;
        m_is       = '0;
        m_cisv     = `IPIC_VOID_VECT;
        m_idx      = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        verify_regs("reset");

        // Random index and ICSR contents with idle lines
        for (int n = 0; n < N_ICSR; n++) begin
            write_idx(rand_bits(32));
            write_icsr(rand_bits(32));
            verify_regs("icsr_access");
        end
        for (int l = 0; l < `IPIC_LINES_NUM; l++) begin
            verify_icsr("icsr_others", line_idx_t'(l));
        end

        // Level mode
        for (int l = 0; l < `IPIC_LINES_NUM; l++) begin
            w = rand_bits(2);
            config_line(line_idx_t'(l), w[0], 1'b0, w[1]);
        end
        for (int n = 0; n < N_LEVEL; n++) begin
            w = rand_bits(16);
            set_lines(w[15:0]);
            verify_regs("level_lines");
            w = rand_bits(16);
            write_ipr(w[15:0]);
            verify_regs("level_clear");
        end

        // Edge mode where an inverted line idles high
        for (int l = 0; l < `IPIC_LINES_NUM; l++) begin
            w = rand_bits(2);
            config_line(line_idx_t'(l), w[0], 1'b1, w[1]);
        end
        idle = m_inv;
        set_lines(idle);
        write_ipr('1);
        verify_regs("edge_idle");
        for (int n = 0; n < N_EDGE; n++) begin
            w = rand_bits(16);
            set_lines(idle ^ w[15:0]);
            verify_regs("edge_pulse");
            w = rand_bits(16);
            write_ipr(w[15:0]);         // Cleared lines must stay clear on return
            set_lines(idle);
            verify_regs("edge_hold");
            w = rand_bits(16);
            write_ipr(w[15:0]);
            verify_regs("edge_clear");
        end

        // Priority and nesting with all lines edge and enabled
        for (int l = 0; l < `IPIC_LINES_NUM; l++) begin
            config_line(line_idx_t'(l), 1'b1, 1'b1, 1'b0);
        end
        set_lines('0);
        write_ipr('1);
        verify_regs("nest_idle");
        for (int n = 0; n < N_NEST; n++) begin
            w = rand_bits(2);
            case (w[1:0])
                2'd2: write_soi();
                2'd3: write_eoi();
                default: begin
                    w = rand_bits(4);
                    pulse_line(w[3:0]);
                end
            endcase
            verify_regs("nest_step");
        end
        repeat (`IPIC_LINES_NUM + 1) begin  // Last ones hit an idle CISV
            write_eoi();
            verify_regs("nest_unwind");
        end
        bus_read(`IPIC_ADDR_CISV, d);
        check_rdata("nest_void", xlen_data_t'(`IPIC_VOID_VECT), d);

        // Unused slot and write-only addresses
        bus_write(ADDR_UNUSED, rand_bits(32));
        bus_read(ADDR_UNUSED, d);
        check_rdata("unused_read", '0, d);
        bus_read(`IPIC_ADDR_EOI, d);
        check_rdata("eoi_read", '0, d);
        bus_read(`IPIC_ADDR_SOI, d);
        check_rdata("soi_read", '0, d);
        verify_regs("unused_write");

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
ipic_pkg.sv
ipic_reg_decode.sv
ipic_irq_line.sv
ipic_serv_ctrl.sv
ipic_top.sv
tb_ipic.sv

// File: run.sh
#!/bin/sh
# Compile and run the IPIC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f all.f --top-module tb_ipic -o tb_ipic

status=0
output=$(./obj_dir/tb_ipic 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
    exit 0
fi
exit 1
